//--- design/frame_pkg.sv
package frame_pkg;

    // Leading word of every frame, ASCII "twir"
    localparam logic [31:0] MSG_ID = 32'h7477_6972;
    localparam int MSG_ID_BITS = 32;

    // Sum of payload bytes modulo 2^16
    typedef logic [15:0] csum_t;

    localparam int CSUM_BYTES = 2;

    // Bytes on the wire for one frame, checksum included when enabled
    function automatic int frame_total_bytes(input int frame_bytes, input int use_csum);
        return frame_bytes + use_csum * CSUM_BYTES;
    endfunction

    function automatic int frame_bits(input int frame_bytes);
        return 8 * frame_bytes;
    endfunction

endpackage

//--- design/uart_pkg.sv
package uart_pkg;

    // Phase of one character on the line
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_START,
        PH_DATA,
        PH_STOP
    } line_phase_t;

    // Quiet line, in bit times, that closes a packet
    localparam int GAP_BITS = 16;

    function automatic int clks_per_bit(input int clk_freq, input int baud);
        return clk_freq / baud;
    endfunction

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
    parameter int CLK_FREQ = 12_000_000,
    parameter int BAUD     = 2_000_000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       end_of_packet
);
    import uart_pkg::*;

    localparam int CPB      = clks_per_bit(CLK_FREQ, BAUD);
    localparam int HALF_BIT = CPB / 2;
    // Counting starts at mid stop bit, hence the extra half bit
    localparam int GAP_CLKS = GAP_BITS * CPB + HALF_BIT - 2;
    localparam int CNT_W    = $clog2(CPB);
    localparam int GAP_W    = $clog2(GAP_CLKS);

    logic             rx_meta;
    logic             rx_sync;
    line_phase_t      phase;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             bit_done;
    logic             stop_ok;
    logic             gap_armed;
    logic [GAP_W-1:0] gap_cnt;

    assign bit_done = (bit_cnt == CNT_W'(CPB - 1));
    assign stop_ok  = (phase == PH_STOP) && bit_done && rx_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase         <= PH_IDLE;
            bit_cnt       <= '0;
            bit_idx       <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        phase <= PH_START;
                    end
                end
                PH_START: begin
                    if (bit_cnt == CNT_W'(HALF_BIT - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // A glitch shorter than half a bit is not a start bit
                        phase   <= rx_sync ? PH_IDLE : PH_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                PH_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            phase <= PH_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                PH_STOP: begin
                    if (bit_done) begin
                        bit_cnt       <= '0;
                        phase         <= PH_IDLE;
                        rx_byte_valid <= rx_sync;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (phase == PH_DATA && bit_done) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (stop_ok) begin
            rx_byte <= shift;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gap_armed     <= 1'b0;
            gap_cnt       <= '0;
            end_of_packet <= 1'b0;
        end else begin
            end_of_packet <= 1'b0;
            if (stop_ok) begin
                gap_armed <= 1'b1;
                gap_cnt   <= '0;
            end else if (gap_armed) begin
                if (phase != PH_IDLE || !rx_sync) begin
                    gap_cnt <= '0;
                end else if (gap_cnt == GAP_W'(GAP_CLKS - 1)) begin
                    gap_armed     <= 1'b0;
                    end_of_packet <= 1'b1;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
        end
    end

    a_byte_not_at_eop: assert property (@(posedge clk) disable iff (rst)
        !(rx_byte_valid && end_of_packet));

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLK_FREQ = 12_000_000,
    parameter int BAUD     = 2_000_000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx,
    output logic       tx_busy
);
    import uart_pkg::*;

    localparam int CPB   = clks_per_bit(CLK_FREQ, BAUD);
    localparam int CNT_W = $clog2(CPB);

    line_phase_t      phase;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       data;
    logic             bit_done;

    assign bit_done = (bit_cnt == CNT_W'(CPB - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= PH_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
            tx_busy <= 1'b0;
        end else begin
            if (phase == PH_IDLE) begin
                bit_cnt <= '0;
            end else if (bit_done) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (phase)
                PH_IDLE: begin
                    if (tx_start) begin
                        tx      <= 1'b0;
                        tx_busy <= 1'b1;
                        phase   <= PH_START;
                    end
                end
                PH_START: begin
                    if (bit_done) begin
                        tx      <= data[0];
                        bit_idx <= '0;
                        phase   <= PH_DATA;
                    end
                end
                PH_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            phase <= PH_STOP;
                        end else begin
                            // data shifts on this same edge
                            tx <= data[1];
                        end
                    end
                end
                PH_STOP: begin
                    if (bit_done) begin
                        tx_busy <= 1'b0;
                        phase   <= PH_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && tx_start) begin
            data <= tx_byte;
        end else if (phase == PH_DATA && bit_done) begin
            data <= data >> 1;
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy);

endmodule

//--- design/frame_receiver.sv
`timescale 1ns/1ns

module frame_receiver #(
    parameter int FRAME_BYTES = 10,
    parameter int USE_CSUM    = 0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 rx_byte,
    input  logic                       rx_byte_valid,
    input  logic                       end_of_packet,
    input  logic                       tx_active,
    output logic [8*FRAME_BYTES-1:0]   rx_frame,
    output logic                       sync
);
    import frame_pkg::*;

    localparam int FRAME_W   = frame_bits(FRAME_BYTES);
    localparam int BUF_BYTES = frame_total_bytes(FRAME_BYTES, USE_CSUM);
    localparam int BUF_W     = 8 * BUF_BYTES;
    localparam int CNT_W     = $clog2(BUF_BYTES + 1);

    logic [BUF_W-1:0]   rx_buf;
    logic [CNT_W-1:0]   byte_cnt;
    logic               overflow;
    csum_t              sum;
    logic               byte_in;
    logic               eop_in;
    logic [FRAME_W-1:0] payload;
    logic               len_ok;
    logic               id_ok;
    logic               csum_ok;

    // Line traffic during our own reply is not a request
    assign byte_in = rx_byte_valid && !tx_active;
    assign eop_in  = end_of_packet && !tx_active;

    assign payload = rx_buf[BUF_W-1 -: FRAME_W];
    assign len_ok  = (byte_cnt == CNT_W'(BUF_BYTES)) && !overflow;
    assign id_ok   = (payload[FRAME_W-1 -: MSG_ID_BITS] == MSG_ID);
    assign csum_ok = (USE_CSUM == 0) || (rx_buf[15:0] == sum);

    always_ff @(posedge clk) begin
        if (byte_in && byte_cnt < CNT_W'(BUF_BYTES)) begin
            rx_buf <= {rx_buf[BUF_W-9:0], rx_byte};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
            overflow <= 1'b0;
            sum      <= '0;
            sync     <= 1'b0;
            rx_frame <= '0;
        end else begin
            sync <= 1'b0;
            if (eop_in) begin
                if (len_ok && id_ok && csum_ok) begin
                    rx_frame <= payload;
                end
                sync     <= 1'b1;
                byte_cnt <= '0;
                overflow <= 1'b0;
                sum      <= '0;
            end else if (byte_in) begin
                if (byte_cnt < CNT_W'(BUF_BYTES)) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt < CNT_W'(FRAME_BYTES)) begin
                        sum <= sum + csum_t'(rx_byte);
                    end
                end else begin
                    // Too long, the packet is dropped at end of packet
                    overflow <= 1'b1;
                end
            end
        end
    end

    a_cnt_in_range: assert property (@(posedge clk) disable iff (rst)
        byte_cnt <= CNT_W'(BUF_BYTES));

endmodule

//--- design/frame_transmitter.sv
`timescale 1ns/1ns

module frame_transmitter #(
    parameter int FRAME_BYTES = 10,
    parameter int USE_CSUM    = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     end_of_packet,
    input  logic [8*FRAME_BYTES-1:0] tx_frame,
    input  logic                     tx_busy,
    output logic                     tx_start,
    output logic [7:0]               tx_byte,
    output logic                     tx_active
);
    import frame_pkg::*;

    localparam int FRAME_W = frame_bits(FRAME_BYTES);
    localparam int TOTAL   = frame_total_bytes(FRAME_BYTES, USE_CSUM);
    localparam int IDX_W   = $clog2(TOTAL + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } tx_state_t;

    tx_state_t          state;
    logic [FRAME_W-1:0] frame_buf;
    csum_t              sum;
    logic [IDX_W-1:0]   idx;
    logic               in_payload;
    logic               last_byte;
    logic               issue;

    assign in_payload = (idx < IDX_W'(FRAME_BYTES));
    assign last_byte  = (idx == IDX_W'(TOTAL - 1));
    assign issue      = (state == ST_ISSUE) && !tx_busy;
    assign tx_start   = issue;

    // Payload first, then checksum high and low byte
    always_comb begin
        if (in_payload) begin
            tx_byte = frame_buf[FRAME_W-1 -: 8];
        end else if (idx == IDX_W'(FRAME_BYTES + CSUM_BYTES - 2)) begin
            tx_byte = sum[15:8];
        end else begin
            tx_byte = sum[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && end_of_packet) begin
            frame_buf <= tx_frame;
        end else if (issue && in_payload) begin
            frame_buf <= frame_buf << 8;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            tx_active <= 1'b0;
            idx       <= '0;
            sum       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (end_of_packet) begin
                        tx_active <= 1'b1;
                        idx       <= '0;
                        sum       <= '0;
                        state     <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (!tx_busy) begin
                        if (in_payload) begin
                            sum <= sum + csum_t'(tx_byte);
                        end
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Busy is already high on the cycle after the start pulse
                    if (!tx_busy) begin
                        if (last_byte) begin
                            tx_active <= 1'b0;
                            state     <= ST_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= ST_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/uart_frame_link.sv
`timescale 1ns/1ns

module uart_frame_link #(
    parameter int CLK_FREQ    = 12_000_000,
    parameter int BAUD        = 2_000_000,
    parameter int FRAME_BYTES = 10,
    parameter int USE_CSUM    = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx,
    output logic                     tx,
    input  logic [8*FRAME_BYTES-1:0] tx_frame,
    output logic [8*FRAME_BYTES-1:0] rx_frame,
    output logic                     sync,
    output logic                     tx_active
);
    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    logic       end_of_packet;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;

    uart_rx #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD     (BAUD)
    ) rx0 (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .end_of_packet (end_of_packet)
    );

    frame_receiver #(
        .FRAME_BYTES (FRAME_BYTES),
        .USE_CSUM    (USE_CSUM)
    ) frx0 (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .end_of_packet (end_of_packet),
        .tx_active     (tx_active),
        .rx_frame      (rx_frame),
        .sync          (sync)
    );

    frame_transmitter #(
        .FRAME_BYTES (FRAME_BYTES),
        .USE_CSUM    (USE_CSUM)
    ) ftx0 (
        .clk           (clk),
        .rst           (rst),
        .end_of_packet (end_of_packet),
        .tx_frame      (tx_frame),
        .tx_busy       (tx_busy),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .tx_active     (tx_active)
    );

    uart_tx #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD     (BAUD)
    ) tx0 (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

//--- include/tb_serial_tasks.svh
`ifndef TB_SERIAL_TASKS_SVH
`define TB_SERIAL_TASKS_SVH

// One bit time on rx, value set on the first rising edge
task automatic line_bit(input logic b);
    @(posedge clk);
    rx <= b;
    repeat (CPB - 1) @(posedge clk);
endtask

// Start bit, 8 data bits LSB first, stop bit
task automatic send_byte(input logic [7:0] b);
    line_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
        line_bit(b[i]);
    end
    line_bit(1'b1);
endtask

// Waits for a start edge on tx during a reply and samples each bit at mid-bit
task automatic receive_byte(output logic [7:0] b, output logic stop_ok);
    @(negedge clk);
    while (!(tx_active === 1'b1 && tx === 1'b0)) begin
        @(negedge clk);
    end
    repeat (CPB / 2 - 1) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        b[i] = tx;
    end
    repeat (CPB) @(negedge clk);
    stop_ok = tx;
endtask

// 16-bit sum of the payload bytes
function automatic logic [15:0] byte_sum(input logic [8*FRAME_BYTES-1:0] f);
    logic [15:0] s;
    s = '0;
    for (int k = 0; k < FRAME_BYTES; k++) begin
        s = s + {8'h00, f[8*k +: 8]};
    end
    return s;
endfunction

// Byte idx of the reply: payload MSB first, then sum high and low
function automatic logic [7:0] reply_byte(input logic [8*FRAME_BYTES-1:0] f, input int idx);
    logic [15:0] s;
    s = byte_sum(f);
    if (idx < FRAME_BYTES) begin
        return f[8*(FRAME_BYTES-1-idx) +: 8];
    end else if (idx == FRAME_BYTES) begin
        return s[15:8];
    end else begin
        return s[7:0];
    end
endfunction

`endif

//--- testbench/tb_uart_frame_link.sv
`timescale 1ns/1ns

module tb_uart_frame_link;
    import frame_pkg::*;
    import uart_pkg::*;

    localparam int CLK_FREQ    = 1_000_000;
    localparam int BAUD        = 100_000;
    localparam int CPB         = CLK_FREQ / BAUD;
    localparam int FRAME_BYTES = 10;
    localparam int USE_CSUM    = 1;
    localparam int WIRE_BYTES  = FRAME_BYTES + CSUM_BYTES;
    localparam int NUM_FRAMES  = 40;
    // Request, gap and reply per frame, 50% margin
    localparam int LIMIT = NUM_FRAMES * (WIRE_BYTES * 10 + GAP_BITS + WIRE_BYTES * 10)
                           * CPB * 3 / 2;

    localparam logic [1:0] K_VALID    = 2'd0;
    localparam logic [1:0] K_BAD_ID   = 2'd1;
    localparam logic [1:0] K_BAD_CSUM = 2'd2;
    localparam logic [1:0] K_BAD_LEN  = 2'd3;

    logic                     clk;
    logic                     rst;
    logic                     rx;
    logic                     tx;
    logic [8*FRAME_BYTES-1:0] tx_frame;
    logic [8*FRAME_BYTES-1:0] rx_frame;
    logic                     sync;
    logic                     tx_active;

    integer                   seed;
    int                       errors;
    int                       cycles;
    int                       sync_count;
    logic [7:0]               wire_q[$];
    logic [7:0]               reply_q[$];
    logic [8*FRAME_BYTES-1:0] exp_rx;

    `include "tb_serial_tasks.svh"

    uart_frame_link #(
        .CLK_FREQ    (CLK_FREQ),
        .BAUD        (BAUD),
        .FRAME_BYTES (FRAME_BYTES),
        .USE_CSUM    (USE_CSUM)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx),
        .tx_frame  (tx_frame),
        .rx_frame  (rx_frame),
        .sync      (sync),
        .tx_active (tx_active)
    );

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [8*FRAME_BYTES-1:0] random_frame();
        logic [8*FRAME_BYTES-1:0] f;
        for (int k = 0; k < FRAME_BYTES; k++) begin
            f[8*k +: 8] = rand_byte();
        end
        return f;
    endfunction

    // Fills wire_q with one request packet of the given kind
    task automatic build_packet(input logic [1:0] kind, output logic [8*FRAME_BYTES-1:0] payload);
        logic [15:0] s;
        logic [7:0]  r;
        payload = random_frame();
        payload[8*FRAME_BYTES-1 -: 32] = MSG_ID;
        if (kind == K_BAD_ID) begin
            payload[8*FRAME_BYTES-1 -: 8] = payload[8*FRAME_BYTES-1 -: 8] ^ (rand_byte() | 8'h01);
        end
        s = byte_sum(payload);
        if (kind == K_BAD_CSUM) begin
            s = s + 16'd1;
        end
        wire_q.delete();
        for (int k = FRAME_BYTES - 1; k >= 0; k--) begin
            wire_q.push_back(payload[8*k +: 8]);
        end
        wire_q.push_back(s[15:8]);
        wire_q.push_back(s[7:0]);
        if (kind == K_BAD_LEN) begin
            r = rand_byte();
            if (r[0]) begin
                void'(wire_q.pop_back());
            end else begin
                wire_q.push_back(rand_byte());
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Errors: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

    always @(negedge clk) begin
        if (sync === 1'b1) begin
            sync_count++;
        end
    end

    // Reply monitor
    initial begin
        logic [7:0] b;
        logic       stop_ok;
        forever begin
            receive_byte(b, stop_ok);
            assert (stop_ok === 1'b1) else begin
                errors++;
                $display("Reply byte %0d was sent with a low stop bit", reply_q.size());
            end
            reply_q.push_back(b);
        end
    end

    initial begin
        logic [8*FRAME_BYTES-1:0] payload;
        logic [8*FRAME_BYTES-1:0] captured;
        logic [31:0]              r;
        logic [1:0]               kind;
        seed       = 32'h011f_75ee;
        errors     = 0;
        sync_count = 0;
        exp_rx     = '0;
        rst      <= 1'b1;
        rx       <= 1'b1;
        tx_frame <= '0;
        repeat (10) @(posedge clk);
        rst      <= 1'b0;
        tx_frame <= random_frame();

        // Idle line after reset
        repeat (100) begin
            @(negedge clk);
            check_value("tx", tx, 1);
            check_value("sync", sync, 0);
            check_value("tx_active", tx_active, 0);
        end

        for (int i = 0; i < NUM_FRAMES; i++) begin
            r    = $random(seed);
            kind = r[1:0];
            build_packet(kind, payload);
            if (kind == K_VALID) begin
                exp_rx = payload;
            end
            reply_q.delete();
            for (int k = 0; k < wire_q.size(); k++) begin
                send_byte(wire_q[k]);
            end

            @(negedge clk);
            while (sync !== 1'b1) begin
                @(negedge clk);
            end
            captured = tx_frame;
            check_value("rx_frame", rx_frame, exp_rx);

            // New host word while this reply is still on the line
            @(posedge clk);
            tx_frame <= random_frame();

            @(negedge clk);
            while (tx_active !== 1'b0) begin
                @(negedge clk);
            end
            check_value("sync_count", sync_count, i + 1);
            check_value("reply_count", reply_q.size(), WIRE_BYTES);
            for (int k = 0; k < reply_q.size() && k < WIRE_BYTES; k++) begin
                check_value($sformatf("tx reply[%0d]", k), reply_q[k], reply_byte(captured, k));
            end
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- uart_frame_link.f
+incdir+include
design/frame_pkg.sv
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/frame_receiver.sv
design/frame_transmitter.sv
design/uart_frame_link.sv
testbench/tb_uart_frame_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_uart_frame_link \
    -Mdir obj_dir \
    -f uart_frame_link.f

sim_output=$(./obj_dir/Vtb_uart_frame_link) || true
echo "$sim_output"

if grep -qx "Finished with no errors" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi
